//--- rtl/xt_chipset_pkg.sv
// Shared types and sizing for the XT chipset core
// Imported by every RTL module and by the testbench
package xt_chipset_pkg;

    // 8088 S2..S0 status codes
    typedef enum logic [2:0] {
        STATUS_INTERRUPT_ACK = 3'b000,
        STATUS_IO_READ       = 3'b001,
        STATUS_IO_WRITE      = 3'b010,
        STATUS_HALT          = 3'b011,
        STATUS_CODE_FETCH    = 3'b100,
        STATUS_MEMORY_READ   = 3'b101,
        STATUS_MEMORY_WRITE  = 3'b110,
        STATUS_PASSIVE       = 3'b111
    } bus_status_t;

    typedef enum logic [2:0] {
        STATE_IDLE    = 3'd0,
        STATE_T1      = 3'd1,
        STATE_T2      = 3'd2,
        STATE_T3      = 3'd3,
        STATE_T4      = 3'd4,
        STATE_REFRESH = 3'd5
    } bus_state_t;

    // Bus sizing
    localparam int ADDR_WIDTH     = 20;
    localparam int DATA_WIDTH     = 8;

    // On-chip RAM occupies the bottom 4 KiB
    localparam int RAM_ADDR_WIDTH = 12;
    localparam int RAM_WORDS      = 1 << RAM_ADDR_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] RAM_LIMIT = ADDR_WIDTH'(RAM_WORDS);

    // Extra T3 cycles for I/O
    localparam int IO_WAIT_STATES   = 1;
    localparam int WAIT_COUNT_WIDTH = $clog2(IO_WAIT_STATES + 1);

    // Refresh timing in clocks
    localparam int REFRESH_PERIOD      = 72;
    localparam int REFRESH_CYCLES      = 4;
    localparam int REFRESH_TIMER_WIDTH = $clog2(REFRESH_PERIOD);
    localparam int REFRESH_COUNT_WIDTH = $clog2(REFRESH_CYCLES);

endpackage

//--- rtl/bus_cycle_controller.sv
`timescale 1ns/1ps
// Bus cycle controller for the 8088 local bus
// Turns a processor status into ALE and one bus command over T1..T4,
// and parks the bus in a refresh state while DMA channel 0 runs
module bus_cycle_controller (
    input  logic                                  clock,
    input  logic                                  reset,
    input  xt_chipset_pkg::bus_status_t           processor_status,
    input  logic [xt_chipset_pkg::ADDR_WIDTH-1:0] cpu_address,
    input  logic                                  cycle_done,
    input  logic                                  refresh_pending,
    input  logic                                  refresh_done,
    output xt_chipset_pkg::bus_state_t            state,
    output logic [xt_chipset_pkg::ADDR_WIDTH-1:0] address,
    output logic                                  address_latch_enable,
    output logic                                  memory_read_n,
    output logic                                  memory_write_n,
    output logic                                  io_read_n,
    output logic                                  io_write_n,
    output logic                                  bus_idle
);
    import xt_chipset_pkg::*;

    bus_state_t next_state;
    logic       cycle_served;
    logic       cpu_request;
    logic       cycle_start;
    logic       command_window;
    logic       cmd_memory_read;
    logic       cmd_memory_write;
    logic       cmd_io_read;
    logic       cmd_io_write;

    // A status stays active until the CPU has seen ready, so block a restart
    // until it has gone passive again
    assign cpu_request = (processor_status != STATUS_PASSIVE) && !cycle_served;

    always_comb begin
        next_state = state;
        case (state)
            STATE_IDLE: begin
                // Refresh wins a tie with a new CPU cycle
                if (refresh_pending)
                    next_state = STATE_REFRESH;
                else if (cpu_request)
                    next_state = STATE_T1;
            end
            STATE_T1: next_state = STATE_T2;
            STATE_T2: next_state = STATE_T3;
            STATE_T3: begin
                if (cycle_done)
                    next_state = STATE_T4;
            end
            STATE_T4: next_state = STATE_IDLE;
            STATE_REFRESH: begin
                if (refresh_done)
                    next_state = STATE_IDLE;
            end
            default: next_state = STATE_IDLE;
        endcase
    end

    assign cycle_start = (state == STATE_IDLE) && (next_state == STATE_T1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= STATE_IDLE;
            cycle_served <= 1'b0;
        end else begin
            state <= next_state;
            if (processor_status == STATUS_PASSIVE)
                cycle_served <= 1'b0;
            else if ((state == STATE_T3) && cycle_done)
                cycle_served <= 1'b1;
        end
    end

    // Code fetch runs as a memory read, halt and INTA get no command
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_memory_read  <= 1'b0;
            cmd_memory_write <= 1'b0;
            cmd_io_read      <= 1'b0;
            cmd_io_write     <= 1'b0;
        end else if (cycle_start) begin
            cmd_memory_read  <= processor_status inside {STATUS_CODE_FETCH, STATUS_MEMORY_READ};
            cmd_memory_write <= (processor_status == STATUS_MEMORY_WRITE);
            cmd_io_read      <= (processor_status == STATUS_IO_READ);
            cmd_io_write     <= (processor_status == STATUS_IO_WRITE);
        end
    end

    always_ff @(posedge clock) begin
        if (cycle_start)
            address <= cpu_address;
    end

    // Commands are low through T2 and T3
    assign command_window = (state == STATE_T2) || (state == STATE_T3);

    assign memory_read_n  = !(cmd_memory_read && command_window);
    assign memory_write_n = !(cmd_memory_write && command_window);
    assign io_read_n      = !(cmd_io_read && command_window);
    assign io_write_n     = !(cmd_io_write && command_window);

    assign address_latch_enable = (state == STATE_T1);
    assign bus_idle             = (state == STATE_IDLE);

    command_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({!memory_read_n, !memory_write_n, !io_read_n, !io_write_n})
    );

endmodule

//--- rtl/ready_logic.sv
`timescale 1ns/1ps
// Ready generator
// Holds the cycle in T3 for I/O wait states, RAM latency and a stalled
// I/O channel, then pulses processor_ready for one clock
module ready_logic (
    input  logic                       clock,
    input  logic                       reset,
    input  xt_chipset_pkg::bus_state_t state,
    input  logic                       io_read_n,
    input  logic                       io_write_n,
    input  logic                       ram_ready,
    input  logic                       ram_hit,
    input  logic                       io_channel_ready,
    output logic                       processor_ready,
    output logic                       cycle_done
);
    import xt_chipset_pkg::*;

    logic [WAIT_COUNT_WIDTH-1:0] wait_count;
    logic                        io_cycle;
    logic                        device_ready;

    assign io_cycle = !io_read_n || !io_write_n;

    // Loaded in T2, runs down during T3
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            wait_count <= '0;
        else if (state == STATE_T2)
            wait_count <= WAIT_COUNT_WIDTH'(IO_WAIT_STATES);
        else if ((state == STATE_T3) && (wait_count != '0))
            wait_count <= wait_count - 1'b1;
    end

    // Off-board memory and no-command cycles need no RAM handshake
    always_comb begin
        if (io_cycle)
            device_ready = (wait_count == '0);
        else
            device_ready = ram_ready || !ram_hit;
    end

    assign cycle_done = (state == STATE_T3) && io_channel_ready && device_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            processor_ready <= 1'b0;
        else
            processor_ready <= cycle_done;
    end

    ready_single_pulse: assert property (
        @(posedge clock) disable iff (reset)
        processor_ready |=> !processor_ready
    );

endmodule

//--- rtl/refresh_request.sv
`timescale 1ns/1ps
// Memory refresh requester
// A free-running timer raises a request every REFRESH_PERIOD clocks;
// it is served as a DMA channel 0 acknowledge once the bus is idle
module refresh_request (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       bus_idle,
    input  xt_chipset_pkg::bus_state_t state,
    output logic                       refresh_pending,
    output logic                       refresh_done,
    output logic                       dma0_acknowledge_n
);
    import xt_chipset_pkg::*;

    logic [REFRESH_TIMER_WIDTH-1:0] refresh_timer;
    logic [REFRESH_COUNT_WIDTH-1:0] acknowledge_count;
    logic                           timer_wrap;
    logic                           request;

    assign timer_wrap = (refresh_timer == REFRESH_TIMER_WIDTH'(REFRESH_PERIOD - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            refresh_timer <= '0;
        else if (timer_wrap)
            refresh_timer <= '0;
        else
            refresh_timer <= refresh_timer + 1'b1;
    end

    // DRQ0 equivalent, dropped when the acknowledge starts
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            request <= 1'b0;
        else if (refresh_pending)
            request <= 1'b0;
        else if (timer_wrap)
            request <= 1'b1;
    end

    // Only offered to the controller between cycles
    assign refresh_pending = request && bus_idle;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            acknowledge_count <= '0;
        else if (state == STATE_REFRESH)
            acknowledge_count <= acknowledge_count + 1'b1;
        else
            acknowledge_count <= '0;
    end

    assign refresh_done = (state == STATE_REFRESH) &&
                          (acknowledge_count == REFRESH_COUNT_WIDTH'(REFRESH_CYCLES - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            dma0_acknowledge_n <= 1'b1;
        else if (refresh_pending)
            dma0_acknowledge_n <= 1'b0;
        else if (refresh_done)
            dma0_acknowledge_n <= 1'b1;
    end

    // Ack only inside the controller's refresh state, so never over a command
    acknowledge_in_refresh: assert property (
        @(posedge clock) disable iff (reset)
        !dma0_acknowledge_n |-> (state == STATE_REFRESH)
    );

endmodule

//--- rtl/system_ram.sv
`timescale 1ns/1ps
// On-chip byte RAM below RAM_LIMIT
// Writes on the first clock of the write command; read data and
// ram_ready follow one clock after the command goes low
module system_ram (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [xt_chipset_pkg::ADDR_WIDTH-1:0] address,
    input  logic [xt_chipset_pkg::DATA_WIDTH-1:0] write_data,
    input  logic                                  memory_read_n,
    input  logic                                  memory_write_n,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0] ram_data,
    output logic                                  ram_hit,
    output logic                                  ram_ready
);
    import xt_chipset_pkg::*;

    logic [DATA_WIDTH-1:0]     memory [RAM_WORDS];
    logic [RAM_ADDR_WIDTH-1:0] index;
    logic                      address_decode;
    logic                      write_n_q;
    logic                      write_enable;

    assign address_decode = (address < RAM_LIMIT);
    assign index          = address[RAM_ADDR_WIDTH-1:0];

    // Hit only while a memory command is on the bus
    assign ram_hit = address_decode && (!memory_read_n || !memory_write_n);

    // Falling edge of the write strobe
    assign write_enable = ram_hit && !memory_write_n && write_n_q;

    always_ff @(posedge clock) begin
        if (write_enable)
            memory[index] <= write_data;
        ram_data <= memory[index];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_n_q <= 1'b1;
            ram_ready <= 1'b0;
        end else begin
            write_n_q <= memory_write_n;
            ram_ready <= ram_hit;
        end
    end

endmodule

//--- rtl/xt_chipset_top.sv
`timescale 1ns/1ps
// XT chipset core top level
// Connects bus control, ready, refresh and the on-chip RAM, steers the
// data bus and captures read data for the CPU at the end of each read
module xt_chipset_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [xt_chipset_pkg::ADDR_WIDTH-1:0] cpu_address,
    input  logic [xt_chipset_pkg::DATA_WIDTH-1:0] cpu_data,
    input  xt_chipset_pkg::bus_status_t           processor_status,
    input  logic                                  io_channel_ready,
    input  logic [xt_chipset_pkg::DATA_WIDTH-1:0] data_bus_ext,
    output logic                                  processor_ready,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0] cpu_read_data,
    output logic [xt_chipset_pkg::ADDR_WIDTH-1:0] address,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0] data_bus,
    output logic                                  address_latch_enable,
    output logic                                  memory_read_n,
    output logic                                  memory_write_n,
    output logic                                  io_read_n,
    output logic                                  io_write_n,
    output logic [3:0]                            dma_acknowledge_n
);
    import xt_chipset_pkg::*;

    bus_state_t            state;
    logic                  cycle_done;
    logic                  refresh_pending;
    logic                  refresh_done;
    logic                  bus_idle;
    logic                  dma0_acknowledge_n;
    logic                  ram_hit;
    logic                  ram_ready;
    logic                  write_active;
    logic                  read_active;
    logic [DATA_WIDTH-1:0] ram_data;
    logic [DATA_WIDTH-1:0] internal_data_bus;

    bus_cycle_controller bus_cycle_controller_i (
        .clock                (clock),
        .reset                (reset),
        .processor_status     (processor_status),
        .cpu_address          (cpu_address),
        .cycle_done           (cycle_done),
        .refresh_pending      (refresh_pending),
        .refresh_done         (refresh_done),
        .state                (state),
        .address              (address),
        .address_latch_enable (address_latch_enable),
        .memory_read_n        (memory_read_n),
        .memory_write_n       (memory_write_n),
        .io_read_n            (io_read_n),
        .io_write_n           (io_write_n),
        .bus_idle             (bus_idle)
    );

    ready_logic ready_logic_i (
        .clock            (clock),
        .reset            (reset),
        .state            (state),
        .io_read_n        (io_read_n),
        .io_write_n       (io_write_n),
        .ram_ready        (ram_ready),
        .ram_hit          (ram_hit),
        .io_channel_ready (io_channel_ready),
        .processor_ready  (processor_ready),
        .cycle_done       (cycle_done)
    );

    refresh_request refresh_request_i (
        .clock              (clock),
        .reset              (reset),
        .bus_idle           (bus_idle),
        .state              (state),
        .refresh_pending    (refresh_pending),
        .refresh_done       (refresh_done),
        .dma0_acknowledge_n (dma0_acknowledge_n)
    );

    system_ram system_ram_i (
        .clock          (clock),
        .reset          (reset),
        .address        (address),
        .write_data     (data_bus),
        .memory_read_n  (memory_read_n),
        .memory_write_n (memory_write_n),
        .ram_data       (ram_data),
        .ram_hit        (ram_hit),
        .ram_ready      (ram_ready)
    );

    // RAM first, then the external bus for I/O and off-board memory
    always_comb begin
        if (!memory_read_n && ram_hit)
            internal_data_bus = ram_data;
        else if (!io_read_n || !memory_read_n)
            internal_data_bus = data_bus_ext;
        else
            internal_data_bus = '0;
    end

    assign write_active = !memory_write_n || !io_write_n;
    assign read_active  = !memory_read_n || !io_read_n;
    assign data_bus     = write_active ? cpu_data : internal_data_bus;

    always_ff @(posedge clock) begin
        if (cycle_done && read_active)
            cpu_read_data <= internal_data_bus;
    end

    // Channels 1 to 3 are not implemented
    assign dma_acknowledge_n = {3'b111, dma0_acknowledge_n};

endmodule

//--- dv/tb_xt_chipset.sv
`timescale 1ns/1ps
// Self-checking testbench for the XT chipset core
// Runs the bus cycles listed in dv/xt_bus_vectors.txt against a RAM model
// and an xorshift-driven external data bus, and watches refresh throughout
module tb_xt_chipset;
    import xt_chipset_pkg::*;

    localparam int MAX_VECTORS  = 64;
    localparam int VECTOR_WORDS = 5 * MAX_VECTORS;

    logic                  clock;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] cpu_address;
    logic [DATA_WIDTH-1:0] cpu_data;
    bus_status_t           processor_status;
    logic                  io_channel_ready;
    logic [DATA_WIDTH-1:0] data_bus_ext;
    logic                  processor_ready;
    logic [DATA_WIDTH-1:0] cpu_read_data;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] data_bus;
    logic                  address_latch_enable;
    logic                  memory_read_n;
    logic                  memory_write_n;
    logic                  io_read_n;
    logic                  io_write_n;
    logic [3:0]            dma_acknowledge_n;

    logic [31:0]           vector_words [VECTOR_WORDS];
    logic [DATA_WIDTH-1:0] model_mem [RAM_WORDS];
    logic [31:0]           rng_state;
    int                    vector_count;
    int                    tests_run;
    int                    tests_failed;
    int                    error_count;
    int                    refresh_count;
    bit                    vector_failed;
    bit                    refresh_failed;

    xt_chipset_top xt_chipset_top_i (
        .clock                (clock),
        .reset                (reset),
        .cpu_address          (cpu_address),
        .cpu_data             (cpu_data),
        .processor_status     (processor_status),
        .io_channel_ready     (io_channel_ready),
        .data_bus_ext         (data_bus_ext),
        .processor_ready      (processor_ready),
        .cpu_read_data        (cpu_read_data),
        .address              (address),
        .data_bus             (data_bus),
        .address_latch_enable (address_latch_enable),
        .memory_read_n        (memory_read_n),
        .memory_write_n       (memory_write_n),
        .io_read_n            (io_read_n),
        .io_write_n           (io_write_n),
        .dma_acknowledge_n    (dma_acknowledge_n)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Command the bus should show for a given status
    function automatic bus_status_t expected_command(input bus_status_t op);
        case (op)
            STATUS_CODE_FETCH, STATUS_MEMORY_READ: return STATUS_MEMORY_READ;
            STATUS_MEMORY_WRITE:                   return STATUS_MEMORY_WRITE;
            STATUS_IO_READ:                        return STATUS_IO_READ;
            STATUS_IO_WRITE:                       return STATUS_IO_WRITE;
            default:                               return STATUS_PASSIVE;
        endcase
    endfunction

    task automatic record_failure();
        error_count++;
        vector_failed = 1'b1;
    endtask

    task automatic report_problem(input string name, input string text);
        $display("%s: %s", name, text);
        record_failure();
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: data expected %h, actual %h", name, expected, actual);
            record_failure();
        end
    endtask

    task automatic check_address(input string name, input logic [ADDR_WIDTH-1:0] expected,
                                 input logic [ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: address expected %h, actual %h", name, expected, actual);
            record_failure();
        end
    endtask

    task automatic check_status(input string name, input bus_status_t expected,
                                input bus_status_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: command expected %s, actual %s", name, expected.name(),
                     actual.name());
            record_failure();
        end
    endtask

    task automatic run_vector(input int index);
        bus_status_t           op;
        bus_status_t           wanted;
        bus_status_t           seen_command;
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] seen_address;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] seen_bus;
        logic [DATA_WIDTH-1:0] expected_byte;
        logic [31:0]           file_expected;
        int                    stall;
        int                    clocks;
        int                    ale_count;
        bit                    ready_seen;
        string                 name;
        op            = bus_status_t'(vector_words[5 * index][2:0]);
        addr          = vector_words[5 * index + 1][ADDR_WIDTH-1:0];
        wdata         = vector_words[5 * index + 2][DATA_WIDTH-1:0];
        stall         = int'(vector_words[5 * index + 3]);
        file_expected = vector_words[5 * index + 4];
        name          = $sformatf("vector %0d %s %h", index, op.name(), addr);
        wanted        = expected_command(op);
        vector_failed = 1'b0;
        seen_command  = STATUS_PASSIVE;
        seen_address  = '0;
        seen_bus      = '0;
        clocks        = 0;
        ale_count     = 0;
        ready_seen    = 1'b0;

        @(negedge clock);
        rng_state        = xorshift32(rng_state);
        data_bus_ext     = rng_state[DATA_WIDTH-1:0];
        processor_status = op;
        cpu_address      = addr;
        cpu_data         = wdata;
        io_channel_ready = (stall == 0);

        while (!ready_seen && clocks < stall + 40) begin
            @(negedge clock);
            clocks++;
            ready_seen = processor_ready;
            if (ready_seen && clocks <= stall)
                report_problem(name, "processor_ready rose while io_channel_ready was low");
            if (clocks >= stall)
                io_channel_ready = 1'b1;
            if (address_latch_enable) begin
                ale_count++;
                seen_address = address;
            end
            if (!$onehot0({!memory_read_n, !memory_write_n, !io_read_n, !io_write_n}))
                report_problem(name, "more than one bus command low at once");
            if (!memory_read_n)
                seen_command = STATUS_MEMORY_READ;
            if (!memory_write_n)
                seen_command = STATUS_MEMORY_WRITE;
            if (!io_read_n)
                seen_command = STATUS_IO_READ;
            if (!io_write_n)
                seen_command = STATUS_IO_WRITE;
            if (!memory_write_n || !io_write_n)
                seen_bus = data_bus;
        end
        // Status held over the edge that sees ready, then passive for a clock
        @(negedge clock);
        processor_status = STATUS_PASSIVE;
        io_channel_ready = 1'b1;

        if (!ready_seen)
            report_problem(name, $sformatf("no processor_ready within %0d clocks", clocks));
        if (ale_count != 1)
            report_problem(name, $sformatf("address latch enable high %0d cycles", ale_count));
        check_status(name, wanted, seen_command);
        check_address(name, addr, seen_address);

        if (wanted == STATUS_MEMORY_WRITE || wanted == STATUS_IO_WRITE) begin
            check_data(name, wdata, seen_bus);
            if (wanted == STATUS_MEMORY_WRITE && addr < RAM_LIMIT)
                model_mem[addr[RAM_ADDR_WIDTH-1:0]] = wdata;
        end else if (wanted == STATUS_MEMORY_READ || wanted == STATUS_IO_READ) begin
            if (wanted == STATUS_IO_READ || addr >= RAM_LIMIT) begin
                expected_byte = data_bus_ext;
            end else begin
                expected_byte = model_mem[addr[RAM_ADDR_WIDTH-1:0]];
                if (file_expected != {24'h0, expected_byte})
                    report_problem(name, "vector file disagrees with the RAM model");
            end
            check_data(name, expected_byte, cpu_read_data);
        end

        tests_run++;
        if (vector_failed)
            tests_failed++;
        $display("%s: %s", name, vector_failed ? "failed" : "pass");
    endtask

    // Refresh acknowledge spacing, overlap with commands, unused channels
    initial begin
        int   quiet_clocks;
        logic previous_ack;
        quiet_clocks = 0;
        previous_ack = 1'b1;
        forever begin
            @(negedge clock);
            if (reset) begin
                quiet_clocks = 0;
                previous_ack = 1'b1;
            end else begin
                quiet_clocks++;
                if (!dma_acknowledge_n[0]) begin
                    quiet_clocks = 0;
                    if (previous_ack)
                        refresh_count++;
                    if (!memory_read_n || !memory_write_n || !io_read_n || !io_write_n) begin
                        $display("refresh: acknowledge low during a bus command");
                        refresh_failed = 1'b1;
                        error_count++;
                    end
                end
                if (dma_acknowledge_n[3:1] !== 3'b111) begin
                    $display("refresh: DMA channels 1 to 3 were acknowledged");
                    refresh_failed = 1'b1;
                    error_count++;
                end
                if (quiet_clocks == REFRESH_PERIOD + 20) begin
                    $display("refresh: no acknowledge within %0d clocks", quiet_clocks);
                    refresh_failed = 1'b1;
                    error_count++;
                end
                previous_ack = dma_acknowledge_n[0];
            end
        end
    end

    initial begin
        wait (vector_count != 0);
        repeat ((vector_count + 4) * (REFRESH_PERIOD + 40)) @(posedge clock);
        $display("watchdog: simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset            = 1'b1;
        cpu_address      = '0;
        cpu_data         = '0;
        processor_status = STATUS_PASSIVE;
        io_channel_ready = 1'b1;
        data_bus_ext     = '0;
        rng_state        = 32'h513d39fd;
        vector_count     = 0;
        tests_run        = 0;
        tests_failed     = 0;
        error_count      = 0;
        refresh_count    = 0;
        refresh_failed   = 1'b0;
        for (int i = 0; i < VECTOR_WORDS; i++)
            vector_words[i] = 32'h7;
        $readmemh("dv/xt_bus_vectors.txt", vector_words);
        while (vector_count < MAX_VECTORS && vector_words[5 * vector_count] != 32'h7)
            vector_count++;
        if (vector_count == 0) begin
            $display("no vectors found in dv/xt_bus_vectors.txt");
            error_count++;
        end

        repeat (16) @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < vector_count; i++)
            run_vector(i);
        // Idle stretch so several refreshes run on a quiet bus
        repeat (3 * REFRESH_PERIOD) @(negedge clock);

        tests_run++;
        if (refresh_failed || refresh_count == 0)
            tests_failed++;
        $display("refresh monitor: %0d acknowledges, %s", refresh_count,
                 (refresh_failed || refresh_count == 0) ? "failed" : "pass");
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- dv/xt_bus_vectors.txt
// status (1 IOR, 2 IOW, 3 halt, 4 fetch, 5 MEMR, 6 MEMW, 0 INTA, 7 end)  address  data
// io_channel_ready stall clocks  expected read byte (100 means data_bus_ext)
6 00010 a5 00 000
6 00011 3c 00 000
6 00012 c3 00 000
6 00011 5a 00 000
5 00010 00 00 0a5
5 00011 00 00 05a
5 00012 00 00 0c3
4 00011 00 00 05a
6 00fff 81 00 000
5 00fff 00 00 081
1 003f8 00 00 100
1 00060 00 03 100
2 003f8 77 00 000
2 00061 e1 05 000
5 01000 00 00 100
5 f0000 00 04 100
6 b8000 42 00 000
3 00000 00 00 000
6 00000 9e 02 000
5 00000 00 00 09e
0 00000 00 00 000
1 00201 00 06 100
4 fe05b 00 00 100
7 00000 00 00 000

//--- verilog.f
rtl/xt_chipset_pkg.sv
rtl/bus_cycle_controller.sv
rtl/ready_logic.sv
rtl/refresh_request.sv
rtl/system_ram.sv
rtl/xt_chipset_top.sv
dv/tb_xt_chipset.sv

//--- run_sim.sh
#!/bin/sh
# Builds the XT chipset testbench with Verilator and runs it.
# Exits non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_xt_chipset

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module "$TOP" -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
